/* src/core_pkg.sv */
`default_nettype none

package core_pkg;

    // widths with a meaning
    typedef logic [31:0] xlen_t;     // data or address word
    typedef logic [31:0] instr_t;    // raw instruction word
    typedef logic [4:0]  reg_idx_t;  // x0..x31
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // major opcodes, standard rv32i encodings
    localparam opcode_t OP_IMM   = 7'b0010011;
    localparam opcode_t OP_R3    = 7'b0110011;
    localparam opcode_t OP_LD    = 7'b0000011;
    localparam opcode_t OP_ST    = 7'b0100011;
    localparam opcode_t OP_BR    = 7'b1100011;
    localparam opcode_t OP_LUI   = 7'b0110111;
    localparam opcode_t OP_AUIPC = 7'b0010111;
    localparam opcode_t OP_JAL   = 7'b1101111;
    localparam opcode_t OP_JALR  = 7'b1100111;

    // funct3 for op / op-imm
    localparam funct3_t F3_ADD  = 3'b000;  // add, sub, addi
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;  // srl / sra by funct7[5]
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // funct3 for branches
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // data memory size
    localparam int DMEM_WORDS = 64;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);  // word address bits

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        PASS_B                                          // lui
    } alu_op_e;

    // write-back source, three-way
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_PC4 = 2'd1,
        WB_MEM = 2'd2
    } wb_sel_e;

    typedef struct packed {
        logic    reg_wr_en;    // rd gets written
        logic    pc_rs1_sel;   // operand a is pc
        logic    imm_rs2_sel;  // operand b is imm
        logic    jump_sel;     // unconditional pc+imm
        logic    branch_en;    // pc+imm if comparator says taken
        logic    jalr_en;      // pc from alu result
        logic    mem_wr_en;
        alu_op_e alu_op;
        wb_sel_e wb_sel;
    } ctrl_t;

endpackage

`default_nettype wire

/* src/control_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module control_unit (
    input  core_pkg::opcode_t opcode,
    input  core_pkg::funct3_t funct3,
    input  core_pkg::funct7_t funct7,  // only bit 5 decoded, rest left for M ext
    output core_pkg::ctrl_t   ctrl
);
    import core_pkg::*;

    // shared arithmetic decode for op and op-imm
    function automatic alu_op_e arith_op(input funct3_t f3, input logic alt,
                                         input logic is_reg);
        alu_op_e res;
        case (f3)
            F3_ADD:  res = (alt && is_reg) ? SUB : ADD;  // no subi
            F3_SLL:  res = SLL;
            F3_SLT:  res = SLT;
            F3_SLTU: res = SLTU;
            F3_XOR:  res = XOR;
            F3_SR:   res = alt ? SRA : SRL;             // srai too
            F3_OR:   res = OR;
            default: res = AND;
        endcase
        return res;
    endfunction

    always_comb begin
        // safe defaults, behaves as a no-op
        ctrl        = '0;
        ctrl.alu_op = ADD;
        ctrl.wb_sel = WB_ALU;

        case (opcode)
            OP_IMM: begin
                ctrl.reg_wr_en   = 1'b1;
                ctrl.imm_rs2_sel = 1'b1;
                ctrl.alu_op      = arith_op(funct3, funct7[5], 1'b0);
            end
            OP_R3: begin
                ctrl.reg_wr_en = 1'b1;
                ctrl.alu_op    = arith_op(funct3, funct7[5], 1'b1);
            end
            OP_LD: begin
                ctrl.reg_wr_en   = 1'b1;
                ctrl.imm_rs2_sel = 1'b1;   // rs1 + offset
                ctrl.wb_sel      = WB_MEM;
            end
            OP_ST: begin
                ctrl.imm_rs2_sel = 1'b1;
                ctrl.mem_wr_en   = 1'b1;
            end
            OP_BR: begin
                ctrl.pc_rs1_sel  = 1'b1;   // alu sums pc+imm, compare is separate
                ctrl.imm_rs2_sel = 1'b1;
                ctrl.branch_en   = 1'b1;
            end
            OP_LUI: begin
                ctrl.reg_wr_en   = 1'b1;
                ctrl.imm_rs2_sel = 1'b1;
                ctrl.alu_op      = PASS_B;
            end
            OP_AUIPC: begin
                ctrl.reg_wr_en   = 1'b1;
                ctrl.pc_rs1_sel  = 1'b1;
                ctrl.imm_rs2_sel = 1'b1;
            end
            OP_JAL: begin
                ctrl.reg_wr_en   = 1'b1;
                ctrl.pc_rs1_sel  = 1'b1;
                ctrl.imm_rs2_sel = 1'b1;
                ctrl.jump_sel    = 1'b1;
                ctrl.wb_sel      = WB_PC4;  // link
            end
            OP_JALR: begin
                ctrl.reg_wr_en   = 1'b1;
                ctrl.imm_rs2_sel = 1'b1;   // target = rs1 + imm
                ctrl.jalr_en     = 1'b1;
                ctrl.wb_sel      = WB_PC4;
            end
            default: ;                      // unknown opcode keeps defaults
        endcase
    end

endmodule

`default_nettype wire

/* src/imm_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module imm_gen (
    input  core_pkg::instr_t instr,
    output core_pkg::xlen_t  imm
);
    import core_pkg::*;

    xlen_t imm_i;
    xlen_t imm_s;
    xlen_t imm_b;
    xlen_t imm_u;
    xlen_t imm_j;

    // every format sign-extends from instr[31]
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};                 // halfword offset
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    always_comb begin
        case (opcode_t'(instr[6:0]))
            OP_IMM, OP_LD, OP_JALR: imm = imm_i;
            OP_ST:                  imm = imm_s;
            OP_BR:                  imm = imm_b;
            OP_LUI, OP_AUIPC:       imm = imm_u;
            OP_JAL:                 imm = imm_j;
            default:                imm = '0;   // r-type has none
        endcase
    end

endmodule

`default_nettype wire

/* src/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  logic              clk,
    input  logic              arst_n,
    input  core_pkg::reg_idx_t rs1_idx,
    input  core_pkg::reg_idx_t rs2_idx,
    output core_pkg::xlen_t    rs1_data,
    output core_pkg::xlen_t    rs2_data,
    input  logic              wr_en,
    input  core_pkg::reg_idx_t wr_idx,
    input  core_pkg::xlen_t    wr_data
);
    import core_pkg::*;

    xlen_t regs [1:31];  // no storage for x0

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_idx != '0)) begin  // x0 writes dropped
            regs[wr_idx] <= wr_data;
        end
    end

    // async reads, x0 hardwired
    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

`default_nettype wire

/* src/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  core_pkg::alu_op_e op,
    input  core_pkg::xlen_t   a,
    input  core_pkg::xlen_t   b,
    input  core_pkg::funct3_t funct3,
    input  core_pkg::xlen_t   cmp_a,  // rs1 for branches
    input  core_pkg::xlen_t   cmp_b,  // rs2 for branches
    output core_pkg::xlen_t   result,
    output logic              taken
);
    import core_pkg::*;

    logic [4:0] shamt;
    logic       eq;
    logic       lt;
    logic       ltu;

    assign shamt = b[4:0];  // low five bits only

    always_comb begin
        case (op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            SLL:     result = a << shamt;
            SLT:     result = {31'b0, $signed(a) < $signed(b)};
            SLTU:    result = {31'b0, a < b};
            XOR:     result = a ^ b;
            SRL:     result = a >> shamt;
            SRA:     result = xlen_t'($signed(a) >>> shamt);  // sign fill
            OR:      result = a | b;
            AND:     result = a & b;
            PASS_B:  result = b;
            default: result = a + b;
        endcase
    end

    // branch comparator, independent of op
    assign eq  = (cmp_a == cmp_b);
    assign lt  = ($signed(cmp_a) < $signed(cmp_b));
    assign ltu = (cmp_a < cmp_b);

    always_comb begin
        case (funct3)
            F3_BEQ:  taken = eq;
            F3_BNE:  taken = !eq;
            F3_BLT:  taken = lt;
            F3_BGE:  taken = !lt;
            F3_BLTU: taken = ltu;
            F3_BGEU: taken = !ltu;
            default: taken = 1'b0;  // 010/011 not defined
        endcase
    end

endmodule

`default_nettype wire

/* src/data_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module data_mem (
    input  logic            clk,
    input  logic            arst_n,
    input  core_pkg::xlen_t addr,     // byte address
    input  logic            wr_en,
    input  core_pkg::xlen_t wr_data,
    output core_pkg::xlen_t rd_data
);
    import core_pkg::*;

    xlen_t              mem [DMEM_WORDS];
    logic [DMEM_AW-1:0] widx;

    // word index, upper bits wrap
    assign widx = addr[DMEM_AW+1:2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[widx] <= wr_data;  // sw only, full word
        end
    end

    assign rd_data = mem[widx];  // async read for lw

endmodule

`default_nettype wire

/* src/rv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core (
    input  logic               clk,
    input  logic               arst_n,
    input  core_pkg::instr_t   instr,
    input  logic               instr_valid,  // commit on next rising edge
    output core_pkg::xlen_t    pc,
    output logic               wb_en,
    output core_pkg::reg_idx_t wb_idx,
    output core_pkg::xlen_t    wb_data
);
    import core_pkg::*;

    // instruction fields
    opcode_t  opcode;
    reg_idx_t rd;
    funct3_t  funct3;
    reg_idx_t rs1;
    reg_idx_t rs2;
    funct7_t  funct7;

    ctrl_t ctrl;
    xlen_t imm;
    xlen_t rs1_data;
    xlen_t rs2_data;
    xlen_t op_a;
    xlen_t op_b;
    xlen_t alu_result;
    logic  taken;
    xlen_t mem_rd_data;
    xlen_t pc_plus4;
    xlen_t pc_target;
    xlen_t pc_next;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    control_unit u_control_unit (
        .opcode (opcode),
        .funct3 (funct3),
        .funct7 (funct7),
        .ctrl   (ctrl)
    );

    imm_gen u_imm_gen (
        .instr (instr),
        .imm   (imm)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_idx  (rs1),
        .rs2_idx  (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wb_en),
        .wr_idx   (rd),
        .wr_data  (wb_data)
    );

    // operand muxes
    assign op_a = ctrl.pc_rs1_sel  ? pc  : rs1_data;
    assign op_b = ctrl.imm_rs2_sel ? imm : rs2_data;

    alu u_alu (
        .op     (ctrl.alu_op),
        .a      (op_a),
        .b      (op_b),
        .funct3 (funct3),
        .cmp_a  (rs1_data),  // comparator always sees the registers
        .cmp_b  (rs2_data),
        .result (alu_result),
        .taken  (taken)
    );

    data_mem u_data_mem (
        .clk     (clk),
        .arst_n  (arst_n),
        .addr    (alu_result),
        .wr_en   (ctrl.mem_wr_en && instr_valid),
        .wr_data (rs2_data),
        .rd_data (mem_rd_data)
    );

    // write-back, only while an instruction is offered
    assign wb_en  = ctrl.reg_wr_en && instr_valid;
    assign wb_idx = rd;

    always_comb begin
        case (ctrl.wb_sel)
            WB_PC4:  wb_data = pc_plus4;     // jal / jalr link
            WB_MEM:  wb_data = mem_rd_data;
            default: wb_data = alu_result;
        endcase
    end

    // next pc
    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + imm;

    always_comb begin
        if (ctrl.jump_sel || (ctrl.branch_en && taken)) begin
            pc_next = pc_target;
        end else if (ctrl.jalr_en) begin
            pc_next = {alu_result[31:1], 1'b0};  // bit 0 cleared
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
        end else if (instr_valid) begin  // hold while idle
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

/* testbench/rv_core_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core_assertions (
    input logic               clk,
    input logic               arst_n,
    input logic               instr_valid,
    input core_pkg::xlen_t    pc,
    input logic               wb_en,
    input core_pkg::reg_idx_t wb_idx,
    input core_pkg::reg_idx_t rs1,       // decoded source index
    input core_pkg::xlen_t    rs1_data
);

    a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        pc[1:0] == 2'b00)
        else $error("pc left word alignment");

    // no write-back without a valid instruction
    a_wb_idle: assert property (@(posedge clk) disable iff (!arst_n)
        !instr_valid |-> !wb_en)
        else $error("wb_en high while instr_valid low");

    a_pc_hold: assert property (@(posedge clk) disable iff (!arst_n)
        !instr_valid |=> $stable(pc))
        else $error("pc moved during an idle cycle");

    // x0 stays zero after a write aimed at it
    a_x0_zero: assert property (@(posedge clk) disable iff (!arst_n)
        (wb_en && wb_idx == 5'd0) |=> (rs1 != 5'd0 || rs1_data == 32'd0))
        else $error("x0 read nonzero after a write to x0");

endmodule

bind rv_core rv_core_assertions u_rv_core_assertions (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .pc          (pc),
    .wb_en       (wb_en),
    .wb_idx      (wb_idx),
    .rs1         (rs1),
    .rs1_data    (rs1_data)
);

`default_nettype wire

/* testbench/tb_rv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core;
    import core_pkg::*;

    // one row per cycle, idle rows have valid low
    typedef struct packed {
        logic [2:0] grp;     // behavior tag 1..5
        logic       valid;
        logic       exp_wb;  // expected wb_en
        instr_t     instr;
    } row_t;

    logic     clk;
    logic     arst_n;
    instr_t   instr;
    logic     instr_valid;
    xlen_t    pc;
    logic     wb_en;
    reg_idx_t wb_idx;
    xlen_t    wb_data;

    row_t  rows[$];
    int    n_rows;
    int    n_idle;
    logic  table_ready;
    int    err_cnt [1:6];
    int    cur_test;
    logic [2:0] prev_grp;

    // reference model state
    xlen_t m_regs [32];
    xlen_t m_mem [DMEM_WORDS];
    xlen_t m_pc;

    rv_core u_rv_core (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .pc          (pc),
        .wb_en       (wb_en),
        .wb_idx      (wb_idx),
        .wb_data     (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    // instruction encoders, straight from the isa formats
    function automatic instr_t r_type(input funct7_t f7, input reg_idx_t rs2,
                                      input reg_idx_t rs1, input funct3_t f3,
                                      input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OP_R3};
    endfunction

    function automatic instr_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                      input funct3_t f3, input reg_idx_t rd,
                                      input opcode_t opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic instr_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
                                      input reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_ST};  // sw
    endfunction

    function automatic instr_t b_type(input logic [12:0] imm, input reg_idx_t rs2,
                                      input reg_idx_t rs1, input funct3_t f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BR};
    endfunction

    function automatic instr_t u_type(input logic [19:0] imm, input reg_idx_t rd,
                                      input opcode_t opc);
        return {imm, rd, opc};
    endfunction

    function automatic instr_t j_type(input logic [20:0] imm, input reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    // rv32i arithmetic rules
    function automatic xlen_t arith(input funct3_t f3, input logic alt, input logic is_reg,
                                    input xlen_t a, input xlen_t b);
        logic signed [31:0] sra;
        sra = $signed(a) >>> b[4:0];
        case (f3)
            3'd0: begin
                if (alt && is_reg) begin
                    return a - b;  // sub only for op
                end
                return a + b;
            end
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5: begin
                if (alt) begin
                    return sra;
                end
                return a >> b[4:0];
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_cond(input funct3_t f3, input xlen_t a, input xlen_t b);
        case (f3)
            3'd0:    return a == b;                       // beq
            3'd1:    return a != b;                       // bne
            3'd4:    return $signed(a) < $signed(b);      // blt
            3'd5:    return $signed(a) >= $signed(b);     // bge
            3'd6:    return a < b;                        // bltu
            3'd7:    return a >= b;                       // bgeu
            default: return 1'b0;
        endcase
    endfunction

    // expected write data, commits regs/mem/pc when the row is valid
    task automatic model_step(input instr_t ins, input logic commit, output xlen_t wd);
        xlen_t    a;
        xlen_t    b;
        xlen_t    imm_i;
        xlen_t    imm_s;
        xlen_t    imm_b;
        xlen_t    imm_j;
        xlen_t    addr;
        xlen_t    npc;
        reg_idx_t rd;
        logic     wr;
        a     = m_regs[ins[19:15]];
        b     = m_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        rd    = ins[11:7];
        wr    = 1'b1;             // most classes write rd
        wd    = '0;
        npc   = m_pc + 32'd4;
        case (opcode_t'(ins[6:0]))
            OP_IMM:   wd = arith(ins[14:12], ins[30], 1'b0, a, imm_i);
            OP_R3:    wd = arith(ins[14:12], ins[30], 1'b1, a, b);
            OP_LD: begin
                addr = a + imm_i;
                wd   = m_mem[addr[DMEM_AW+1:2]];  // word index wraps
            end
            OP_ST: begin
                addr = a + imm_s;
                wr   = 1'b0;
                if (commit) begin
                    m_mem[addr[DMEM_AW+1:2]] = b;
                end
            end
            OP_BR: begin
                wr = 1'b0;
                if (branch_cond(ins[14:12], a, b)) begin
                    npc = m_pc + imm_b;
                end
            end
            OP_LUI:   wd = {ins[31:12], 12'h000};
            OP_AUIPC: wd = m_pc + {ins[31:12], 12'h000};
            OP_JAL: begin
                wd  = m_pc + 32'd4;
                npc = m_pc + imm_j;
            end
            OP_JALR: begin
                wd  = m_pc + 32'd4;
                npc = (a + imm_i) & ~32'd1;    // lsb dropped
            end
            default:  wr = 1'b0;                 // unknown opcode, no-op
        endcase
        if (commit) begin
            if (wr && (rd != 5'd0)) begin
                m_regs[rd] = wd;
            end
            m_pc = npc;
        end
    endtask

    task automatic check(input string name, input xlen_t exp, input xlen_t act);
        if (exp !== act) begin
            $display("Mismatch at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
            err_cnt[cur_test]++;
        end
    endtask

    // appends a row, sometimes preceded by an idle cycle with a random word
    task automatic add_row(input logic [2:0] grp, input instr_t ins, input logic exp_wb);
        row_t r;
        if ($urandom_range(3, 0) == 0) begin
            r.grp    = grp;
            r.valid  = 1'b0;
            r.exp_wb = 1'b0;
            r.instr  = $urandom;
            rows.push_back(r);
            n_idle++;
        end
        r.grp    = grp;
        r.valid  = 1'b1;
        r.exp_wb = exp_wb;
        r.instr  = ins;
        rows.push_back(r);
        n_rows++;
    endtask

    task automatic load_const(input logic [2:0] grp, input reg_idx_t rd, input xlen_t val);
        xlen_t hi;
        hi = val + 32'h800;  // undo addi sign extension
        add_row(grp, u_type(hi[31:12], rd, OP_LUI), 1'b1);
        add_row(grp, i_type(val[11:0], rd, F3_ADD, rd, OP_IMM), 1'b1);
    endtask

    task automatic build_table();
        funct3_t f3;
        // 1 arithmetic, x1 negative so sra shows sign fill
        load_const(3'd1, 5'd1, $urandom | 32'h8000_0000);
        load_const(3'd1, 5'd2, $urandom);
        load_const(3'd1, 5'd3, xlen_t'($urandom_range(31, 0)));  // shift amount
        for (int k = 0; k < 8; k++) begin
            f3 = funct3_t'(k);
            add_row(3'd1, r_type(7'h00, 5'd2, 5'd1, f3, 5'd5), 1'b1);
            if (k != 1 && k != 5) begin
                add_row(3'd1, i_type(12'($urandom), 5'd1, f3, 5'd4, OP_IMM), 1'b1);
            end
        end
        add_row(3'd1, r_type(7'h20, 5'd2, 5'd1, F3_ADD, 5'd5), 1'b1);  // sub
        add_row(3'd1, r_type(7'h20, 5'd3, 5'd1, F3_SR, 5'd5), 1'b1);   // sra
        add_row(3'd1, r_type(7'h00, 5'd3, 5'd1, F3_SLL, 5'd6), 1'b1);
        add_row(3'd1, i_type({7'h00, 5'd3}, 5'd1, F3_SLL, 5'd4, OP_IMM), 1'b1);
        add_row(3'd1, i_type({7'h00, 5'd9}, 5'd1, F3_SR, 5'd4, OP_IMM), 1'b1);
        add_row(3'd1, i_type({7'h20, 5'd9}, 5'd1, F3_SR, 5'd4, OP_IMM), 1'b1);  // srai
        // 2 upper immediates and x0
        add_row(3'd2, u_type(20'($urandom), 5'd6, OP_LUI), 1'b1);
        add_row(3'd2, u_type(20'($urandom), 5'd7, OP_AUIPC), 1'b1);
        add_row(3'd2, i_type(12'h055, 5'd0, F3_ADD, 5'd0, OP_IMM), 1'b1);
        add_row(3'd2, u_type(20'habcde, 5'd0, OP_LUI), 1'b1);
        add_row(3'd2, r_type(7'h00, 5'd0, 5'd0, F3_OR, 5'd8), 1'b1);   // x0 reads zero
        add_row(3'd2, r_type(7'h00, 5'd0, 5'd6, F3_ADD, 5'd9), 1'b1);
        // 3 memory, base 0x40
        load_const(3'd3, 5'd10, 32'h40);
        load_const(3'd3, 5'd11, $urandom);
        load_const(3'd3, 5'd12, $urandom);
        add_row(3'd3, s_type(12'h000, 5'd11, 5'd10), 1'b0);
        add_row(3'd3, s_type(12'h008, 5'd12, 5'd10), 1'b0);
        add_row(3'd3, s_type(12'hffc, 5'd12, 5'd10), 1'b0);           // 0x3c
        add_row(3'd3, i_type(12'h000, 5'd10, 3'b010, 5'd13, OP_LD), 1'b1);
        add_row(3'd3, i_type(12'h008, 5'd10, 3'b010, 5'd14, OP_LD), 1'b1);
        add_row(3'd3, i_type(12'hffc, 5'd10, 3'b010, 5'd15, OP_LD), 1'b1);
        add_row(3'd3, i_type(12'h004, 5'd10, 3'b010, 5'd16, OP_LD), 1'b1);  // never stored
        add_row(3'd3, i_type(12'h100, 5'd10, 3'b010, 5'd17, OP_LD), 1'b1);  // wraps to 0x40
        // 4 branches: x18 positive, x19 equal to it, x20 negative
        load_const(3'd4, 5'd18, $urandom & 32'h7fff_ffff);
        add_row(3'd4, r_type(7'h00, 5'd0, 5'd18, F3_ADD, 5'd19), 1'b1);
        load_const(3'd4, 5'd20, $urandom | 32'h8000_0000);
        for (int k = 0; k < 8; k++) begin
            if (k == 2 || k == 3) begin
                continue;  // no branch there
            end
            f3 = funct3_t'(k);
            add_row(3'd4, b_type(13'd16, 5'd19, 5'd18, f3), 1'b0);
            add_row(3'd4, b_type(-13'sd8, 5'd20, 5'd18, f3), 1'b0);
            add_row(3'd4, b_type(13'd12, 5'd18, 5'd20, f3), 1'b0);
        end
        // 5 jumps, jalr targets land word aligned after bit 0 clear
        add_row(3'd5, j_type(21'h40, 5'd21), 1'b1);
        add_row(3'd5, j_type(-21'sd32, 5'd22), 1'b1);
        load_const(3'd5, 5'd7, 32'h205);
        add_row(3'd5, i_type(12'h000, 5'd7, 3'b000, 5'd23, OP_JALR), 1'b1);
        add_row(3'd5, i_type(12'hfff, 5'd7, 3'b000, 5'd24, OP_JALR), 1'b1);
        add_row(3'd5, i_type(12'h00f, 5'd7, 3'b000, 5'd25, OP_JALR), 1'b1);
        add_row(3'd5, j_type(21'h8, 5'd0), 1'b1);                      // link dropped
        add_row(3'd5, r_type(7'h00, 5'd23, 5'd21, F3_ADD, 5'd26), 1'b1);
    endtask

    function automatic string test_name(input logic [2:0] t);
        case (t)
            3'd1:    return "arithmetic";
            3'd2:    return "upper immediates";
            3'd3:    return "memory";
            3'd4:    return "branches";
            3'd5:    return "jumps";
            default: return "stall and reset";
        endcase
    endfunction

    task automatic report_test(input logic [2:0] t);
        $display("test %0d %s: %s, %0d errors", t, test_name(t),
                 (err_cnt[t] == 0) ? "passed" : "failed", err_cnt[t]);
    endtask

    // drive at +2, check wb before the edge, pc after it
    task automatic apply_row(input row_t r);
        xlen_t wd;
        @(posedge clk);
        #2;
        check("pc", m_pc, pc);  // result of the previous row
        if (r.grp != prev_grp) begin
            report_test(prev_grp);
            prev_grp = r.grp;
        end
        cur_test    = r.valid ? int'(r.grp) : 6;  // idle rows count as stall test
        instr       = r.instr;
        instr_valid = r.valid;
        #10;
        model_step(r.instr, r.valid, wd);
        check("wb_en", 32'(r.exp_wb), 32'(wb_en));
        if (r.exp_wb) begin
            check("wb_idx", 32'(r.instr[11:7]), 32'(wb_idx));
            check("wb_data", wd, wb_data);
        end
    endtask

    // watchdog sized from the table
    initial begin
        wait (table_ready);
        #((n_rows + n_idle + 20) * 20);
        $display("Timeout: the testbench did not finish within the expected run time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int    n_pass;
        arst_n      = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        table_ready = 1'b0;
        n_rows      = 0;
        n_idle      = 0;
        cur_test    = 6;
        prev_grp    = 3'd1;
        m_pc        = '0;
        foreach (err_cnt[t]) err_cnt[t] = 0;
        foreach (m_regs[i]) m_regs[i] = '0;
        foreach (m_mem[i]) m_mem[i] = '0;
        void'($urandom(32'hcc329d4d));
        build_table();
        table_ready = 1'b1;

        repeat (10) @(posedge clk);
        #2;
        arst_n = 1'b1;
        #10;
        check("pc", 32'd0, pc);             // fresh out of reset
        check("wb_en", 32'd0, 32'(wb_en));

        foreach (rows[k]) begin
            apply_row(rows[k]);
        end
        @(posedge clk);
        #2;
        check("pc", m_pc, pc);
        report_test(prev_grp);
        report_test(3'd6);

        n_pass = 0;
        for (int t = 1; t <= 6; t++) begin
            if (err_cnt[t] == 0) begin
                n_pass++;
            end
        end
        $display("Tests passed: %0d, failed: %0d", n_pass, 6 - n_pass);
        if (n_pass == 6) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
src/core_pkg.sv
src/control_unit.sv
src/imm_gen.sv
src/reg_file.sv
src/alu.sv
src/data_mem.sv
src/rv_core.sv
testbench/rv_core_assertions.sv
testbench/tb_rv_core.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert --timing -Wno-fatal
TOP       = tb_rv_core
FILELIST  = all.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
